/* tb.f */
+incdir+hw
hw/corePkg.sv
hw/instBuf.sv
hw/ctrlUnit.sv
hw/branchUnit.sv
hw/regFile.sv
hw/execUnit.sv
hw/coreTop.sv
dv/coreTb.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module coreTb \
  -Mdir "$BUILD" -o coreTb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD/coreTb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -qx "Simulation completed successfully" "$LOG"; then
  exit 0
fi
exit 1

/* dv/coreTb.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module coreTb;

  // MicroBlaze primary opcodes used by the program
  localparam logic [5:0] OP_ADD  = 6'h00;
  localparam logic [5:0] OP_RSUB = 6'h01;
  localparam logic [5:0] OP_ADDI = 6'h08;
  localparam logic [5:0] OP_BS   = 6'h19;
  localparam logic [5:0] OP_OR   = 6'h20;
  localparam logic [5:0] OP_AND  = 6'h21;
  localparam logic [5:0] OP_XOR  = 6'h22;
  localparam logic [5:0] OP_BRI  = 6'h2E;
  localparam logic [5:0] OP_BCC  = 6'h2F;
  localparam logic [5:0] OP_LWI  = 6'h3A;
  localparam logic [5:0] OP_SWI  = 6'h3E;

  localparam int          IMEM_WORDS    = 64;
  localparam int          DMEM_WORDS    = 256;
  localparam int          STORE_TIMEOUT = 3000; // Cycles per run
  localparam int          QUIET_CYCLES  = 40;   // Watch for stray stores
  localparam logic [31:0] LOAD_ADDR     = 32'h0000_0200;
  localparam logic [31:0] LOAD_VALUE    = 32'h1357_9BDF;

  logic                gclk;
  logic                grst;
  logic [`CORE_DW-1:0] iAddr;
  logic                iEn;
  logic [`CORE_DW-1:0] iData = '0;
  logic                iBusyN;
  logic [`CORE_DW-1:0] dAddr;
  logic                dEn;
  logic                dWe;
  logic [`CORE_DW-1:0] dDataOut;
  logic [`CORE_DW-1:0] dData = '0;
  logic                dBusyN;

  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] dmem [DMEM_WORDS];
  logic [31:0] expAddr [$];
  logic [31:0] expData [$];

  // Port state as seen at the falling edge, used on the next rising edge
  logic        iAccS  = 1'b0;
  logic [31:0] iAddrS = '0;
  logic        dRdS   = 1'b0;
  logic [31:0] dAddrS = '0;
  logic        rstEdge = 1'b0; // Last rising edge saw reset low

  int    progLen     = 0;
  int    storeIdx    = 0;
  int    storesTotal = 0;
  int    errCount    = 0;
  int    sinceRst    = 0;
  logic  fetchSeen   = 1'b0;
  logic  busyOn      = 1'b0;
  string testName    = "reset";

  coreTop uut (
    .gclk       (gclk),
    .grst       (grst),
    .iAddr_o    (iAddr),
    .iEn_o      (iEn),
    .iData_i    (iData),
    .iBusyN_i   (iBusyN),
    .dAddr_o    (dAddr),
    .dEn_o      (dEn),
    .dWe_o      (dWe),
    .dDataOut_o (dDataOut),
    .dData_i    (dData),
    .dBusyN_i   (dBusyN)
  );

  initial
  begin
    gclk = 1'b0;
    forever #5 gclk = ~gclk;
  end

  function automatic logic [31:0] encR(input logic [5:0] opc, input logic [4:0] rd,
                                        input logic [4:0] ra, input logic [4:0] rb);
    return {opc, rd, ra, rb, 11'd0};
  endfunction

  function automatic logic [31:0] encI(input logic [5:0] opc, input logic [4:0] rd,
                                        input logic [4:0] ra, input logic [15:0] imm);
    return {opc, rd, ra, imm};
  endfunction

  task automatic reportValue(input string what, input logic [31:0] expVal,
                             input logic [31:0] actVal);
    errCount++;
    $display("[FAIL] %s %s: expected %h, actual %h", testName, what, expVal, actVal);
  endtask

  task automatic reportText(input string msg);
    errCount++;
    $display("ERROR in %s: %s", testName, msg);
  endtask

  task automatic emit(input logic [31:0] word);
    imem[progLen] = word;
    progLen++;
  endtask

  task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  // Expected values follow the ISA by hand, r10 is the store base 0x100
  task automatic buildProgram();
    for (int w = 0; w < IMEM_WORDS; w++)
      imem[w] = encI(OP_ADDI, 5'd0, 5'd0, 16'(w)); // NOP into r0, tagged with its index
    emit(encI(OP_ADDI, 5'd1, 5'd0, 16'd100));   // r1 = 100
    emit(encI(OP_ADDI, 5'd2, 5'd1, 16'd23));    // r2 = 123, r1 forwarded
    emit(encR(OP_ADD, 5'd3, 5'd1, 5'd2));       // r3 = 223
    emit(encR(OP_RSUB, 5'd4, 5'd3, 5'd2));      // r4 = r2 - r3
    emit(encI(OP_ADDI, 5'd10, 5'd0, 16'h0100));
    emit(encI(OP_SWI, 5'd3, 5'd10, 16'd0));
    expectStore(32'h100, 32'd223);
    emit(encI(OP_SWI, 5'd4, 5'd10, 16'd4));
    expectStore(32'h104, 32'hFFFF_FF9C);        // -100
    emit(encI(OP_ADDI, 5'd5, 5'd0, 16'h0F0F));
    emit(encI(OP_ADDI, 5'd6, 5'd0, 16'h00FF));
    emit(encR(OP_OR, 5'd7, 5'd5, 5'd6));        // 0x0FFF
    emit(encR(OP_AND, 5'd8, 5'd7, 5'd5));       // 0x0F0F
    emit(encR(OP_XOR, 5'd9, 5'd8, 5'd6));       // 0x0FF0
    emit(encI(OP_SWI, 5'd9, 5'd10, 16'd16));    // Store data straight from execute
    expectStore(32'h110, 32'h0000_0FF0);
    emit(encI(OP_SWI, 5'd7, 5'd10, 16'd8));
    expectStore(32'h108, 32'h0000_0FFF);
    emit(encI(OP_SWI, 5'd8, 5'd10, 16'd12));
    expectStore(32'h10C, 32'h0000_0F0F);
    if (`CORE_BSF != 0)
    begin
      emit(encI(OP_ADDI, 5'd12, 5'd0, 16'h8001)); // Sign extends to 0xFFFF8001
      emit(encI(OP_BS, 5'd13, 5'd12, 16'h0404));  // BSLLI by 4
      emit(encI(OP_BS, 5'd14, 5'd12, 16'h0008));  // BSRLI by 8
      emit(encI(OP_SWI, 5'd13, 5'd10, 16'd20));
      expectStore(32'h114, 32'hFFF8_0010);
      emit(encI(OP_SWI, 5'd14, 5'd10, 16'd24));
      expectStore(32'h118, 32'h00FF_FF80);
    end
    emit(encI(OP_LWI, 5'd15, 5'd10, 16'h0100)); // From LOAD_ADDR
    emit(encI(OP_ADDI, 5'd0, 5'd0, 16'd5));     // Write to r0 is dropped
    emit(encI(OP_ADDI, 5'd17, 5'd0, 16'd7));
    emit(encI(OP_ADDI, 5'd16, 5'd15, 16'd1));
    emit(encI(OP_SWI, 5'd16, 5'd10, 16'h0104));
    expectStore(32'h204, LOAD_VALUE + 32'd1);
    emit(encI(OP_SWI, 5'd17, 5'd10, 16'd28));
    expectStore(32'h11C, 32'd7);
    emit(encI(OP_ADDI, 5'd18, 5'd0, 16'd0));
    emit(encI(OP_BCC, 5'd0, 5'd18, 16'd12));    // BEQI taken
    emit(encI(OP_SWI, 5'd1, 5'd10, 16'd32));    // Squashed
    emit(encI(OP_SWI, 5'd2, 5'd10, 16'd36));    // Jumped over
    emit(encI(OP_ADDI, 5'd19, 5'd0, 16'd3));
    emit(encI(OP_BCC, 5'd1, 5'd18, 16'd8));     // BNEI not taken
    emit(encI(OP_SWI, 5'd19, 5'd10, 16'd40));
    expectStore(32'h128, 32'd3);
    emit(encI(OP_BRI, 5'd0, 5'd0, 16'd12));
    emit(encI(OP_SWI, 5'd1, 5'd10, 16'd44));    // Squashed
    emit(encI(OP_SWI, 5'd2, 5'd10, 16'd48));    // Jumped over
    emit(encI(OP_SWI, 5'd3, 5'd10, 16'd52));    // Branch target
    expectStore(32'h134, 32'd223);
    emit(encI(OP_BRI, 5'd0, 5'd0, 16'd0));      // Park in a self loop
  endtask

  // Every word holds its own byte address in the low half
  task automatic fillData();
    for (int w = 0; w < DMEM_WORDS; w++)
      dmem[w] = 32'hC0DE_0000 | 32'(w * 4);
    dmem[LOAD_ADDR[9:2]] = LOAD_VALUE;
  endtask

  task automatic checkStore();
    assert (storeIdx < expAddr.size())
    else reportText($sformatf("store to %h beyond the expected sequence", dAddr));
    if (storeIdx < expAddr.size())
    begin
      assert (dAddr == expAddr[storeIdx])
      else reportValue("store address", expAddr[storeIdx], dAddr);
      assert (dDataOut == expData[storeIdx])
      else reportValue("store data", expData[storeIdx], dDataOut);
    end
    dmem[dAddr[9:2]] = dDataOut;
    storeIdx++;
  endtask

  // Everything settles within a nanosecond of the rising edge, the falling edge sees stable values
  always @(negedge gclk)
  begin
    iAccS  = iEn;
    iAddrS = iAddr;
    dRdS   = dEn && !dWe;
    dAddrS = dAddr;
    if (!grst)
    begin
      sinceRst  = 0;
      fetchSeen = 1'b0;
    end
    else
      sinceRst++;
    // Synchronous reset, enables are only cleared once an edge has seen it
    if (rstEdge || (grst && sinceRst <= 2))
    begin
      assert (!iEn && !dEn && !dWe)
      else reportText("a port enable is high during or right after reset");
    end
    if (grst && iEn && !fetchSeen)
    begin
      assert (iAddr == `CORE_RESET_PC)
      else reportValue("first fetch address", `CORE_RESET_PC, iAddr);
      fetchSeen = 1'b1;
    end
    if (dEn && dWe)
      checkStore();
  end

  // Memories answer one cycle after an accepted access, then hold
  always @(posedge gclk)
  begin
    rstEdge = !grst; // Same sample the DUT flops take
    #1;
    if (iAccS)
      iData = imem[iAddrS[7:2]];
    if (dRdS)
      dData = dmem[dAddrS[9:2]];
  end

  task automatic tick();
    @(posedge gclk);
    #1;
    if (busyOn)
    begin
      iBusyN = ($urandom % 4) != 0; // Busy about one cycle in four
      dBusyN = ($urandom % 4) != 0;
    end
    else
    begin
      iBusyN = 1'b1;
      dBusyN = 1'b1;
    end
  endtask

  task automatic runProgram(input string name);
    int cycles;
    testName = name;
    grst     = 1'b0;
    storeIdx = 0;
    fillData();
    repeat (2) tick();
    grst   = 1'b1;
    cycles = 0;
    while (storeIdx < expAddr.size() && cycles < STORE_TIMEOUT)
    begin
      tick();
      cycles++;
    end
    assert (storeIdx >= expAddr.size())
    else reportText($sformatf("timed out with %0d of %0d stores seen",
                              storeIdx, expAddr.size()));
    repeat (QUIET_CYCLES) tick(); // Late or repeated stores show up here
    storesTotal += storeIdx;
  endtask

  initial
  begin
    void'($urandom(32'hec72));
    grst   = 1'b0;
    iBusyN = 1'b1;
    dBusyN = 1'b1;
    buildProgram();
    runProgram("nominal");
    busyOn = 1'b1;
    runProgram("backpressure"); // Same program, same stores expected
    $display("Stores checked: %0d, errors: %0d", storesTotal, errCount);
    if (errCount == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* hw/coreTop.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module coreTop
  import corePkg::*;
(
  input  logic                gclk,
  input  logic                grst,
  output logic [`CORE_DW-1:0] iAddr_o,
  output logic                iEn_o,
  input  logic [`CORE_DW-1:0] iData_i,
  input  logic                iBusyN_i,
  output logic [`CORE_DW-1:0] dAddr_o,
  output logic                dEn_o,
  output logic                dWe_o,
  output logic [`CORE_DW-1:0] dDataOut_o,
  input  logic [`CORE_DW-1:0] dData_i,
  input  logic                dBusyN_i
);

  logic dEn;
  logic xEn;
  logic dEnPrev;
  logic grstPrev;

  opcT                 opc;
  logic [4:0]          rd;
  logic [4:0]          ra;
  logic [4:0]          rb;
  logic [`CORE_DW-1:0] simm;
  logic [10:0]         alt;
  srcSelT              srcSel;
  tgtSelT              tgtSel;
  aluSelT              aluSel;
  dstSelT              dstSel;
  logic [4:0]          rw;
  logic [`CORE_DW-1:0] pc;
  logic                skip;
  logic [`CORE_DW-1:0] regA;
  logic [`CORE_DW-1:0] regB;
  logic [`CORE_DW-1:0] loadData;
  logic [`CORE_DW-1:0] result;
  logic [`CORE_DW-1:0] resultFwd;

  assign dEn = iBusyN_i; // Instruction port ready

  // Reset delay, pipeline starts two cycles after release
  always_ff @(posedge gclk)
  begin
    if (!grst)
    begin
      grstPrev <= 1'b0;
      dEnPrev  <= 1'b0;
    end
    else
    begin
      grstPrev <= 1'b1;
      dEnPrev  <= dEn && grstPrev;
    end
  end

  // Global advance, either port busy holds everything
  assign xEn   = dEnPrev && dEn && dBusyN_i;
  assign iEn_o = xEn;

  // Decode register moves with the pipeline
  instBuf uIbuf (
    .gclk    (gclk),
    .grst    (grst),
    .dEn_i   (xEn),
    .iData_i (iData_i),
    .opc_o   (opc),
    .rd_o    (rd),
    .ra_o    (ra),
    .rb_o    (rb),
    .imm_o   (),
    .simm_o  (simm),
    .alt_o   (alt),
    .iReg_o  ()
  );

  ctrlUnit uCtrl (
    .gclk     (gclk),
    .grst     (grst),
    .xEn_i    (xEn),
    .skip_i   (skip),
    .opc_i    (opc),
    .rd_i     (rd),
    .ra_i     (ra),
    .rb_i     (rb),
    .srcSel_o (srcSel),
    .tgtSel_o (tgtSel),
    .aluSel_o (aluSel),
    .dstSel_o (dstSel),
    .rw_o     (rw),
    .dEn_o    (dEn_o),
    .dWe_o    (dWe_o)
  );

  branchUnit uBpcu (
    .gclk    (gclk),
    .grst    (grst),
    .xEn_i   (xEn),
    .opc_i   (opc),
    .rd_i    (rd),
    .regA_i  (resultFwd),
    .simm_i  (simm),
    .iAddr_o (iAddr_o),
    .pc_o    (pc),
    .skip_o  (skip)
  );

  regFile uRegf (
    .gclk       (gclk),
    .grst       (grst),
    .xEn_i      (xEn),
    .ra_i       (ra),
    .rb_i       (rb),
    .rd_i       (rd),
    .rw_i       (rw),
    .dstSel_i   (dstSel),
    .result_i   (result),
    .dData_i    (dData_i),
    .regA_o     (regA),
    .regB_o     (regB),
    .regD_o     (),
    .loadData_o (loadData),
    .dDataOut_o (dDataOut_o)
  );

  execUnit uXecu (
    .gclk        (gclk),
    .grst        (grst),
    .xEn_i       (xEn),
    .regA_i      (regA),
    .regB_i      (regB),
    .simm_i      (simm),
    .pc_i        (pc),
    .srcSel_i    (srcSel),
    .tgtSel_i    (tgtSel),
    .aluSel_i    (aluSel),
    .opc_i       (opc),
    .alt_i       (alt),
    .loadData_i  (loadData),
    .result_o    (result),
    .resultFwd_o (resultFwd),
    .dAddr_o     (dAddr_o)
  );

endmodule

/* hw/execUnit.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module execUnit
  import corePkg::*;
(
  input  logic                gclk,
  input  logic                grst,
  input  logic                xEn_i,
  input  logic [`CORE_DW-1:0] regA_i,
  input  logic [`CORE_DW-1:0] regB_i,
  input  logic [`CORE_DW-1:0] simm_i,
  input  logic [`CORE_DW-1:0] pc_i,
  input  srcSelT              srcSel_i,
  input  tgtSelT              tgtSel_i,
  input  aluSelT              aluSel_i,
  input  opcT                 opc_i,
  input  logic [10:0]         alt_i,
  input  logic [`CORE_DW-1:0] loadData_i, // Write-back value
  output logic [`CORE_DW-1:0] result_o,
  output logic [`CORE_DW-1:0] resultFwd_o,
  output logic [`CORE_DW-1:0] dAddr_o
);

  logic [`CORE_DW-1:0] opA;
  logic [`CORE_DW-1:0] opB;
  logic [`CORE_DW-1:0] fwdA;
  logic [`CORE_DW-1:0] shiftOut;
  logic [`CORE_DW-1:0] aluOut;
  logic [`CORE_DW-1:0] rResult;

  // ra after forwarding, ignores the PC select
  assign fwdA = (srcSel_i == SRC_FWD) ? loadData_i : regA_i;

  always_comb
  begin
    case (srcSel_i)
      SRC_FWD: opA = loadData_i;
      SRC_PC:  opA = pc_i;
      default: opA = regA_i;
    endcase
    case (tgtSel_i)
      TGT_FWD: opB = loadData_i;
      TGT_IMM: opB = simm_i;
      default: opB = regB_i;
    endcase
  end

  // Barrel shifter, bit 10 set shifts left
  always_comb
  begin
    shiftOut = '0;
    if ((`CORE_BSF != 0) && (opc_i == OPC_BSI))
    begin
      if (alt_i[10])
        shiftOut = opA << simm_i[4:0];
      else
        shiftOut = opA >> simm_i[4:0]; // Logical
    end
  end

  always_comb
  begin
    case (aluSel_i)
      ALU_RSUB:  aluOut = opB - opA;
      ALU_OR:    aluOut = opA | opB;
      ALU_AND:   aluOut = opA & opB;
      ALU_XOR:   aluOut = opA ^ opB;
      ALU_SHIFT: aluOut = shiftOut;
      default:   aluOut = opA + opB;
    endcase
  end

  always_ff @(posedge gclk)
  begin
    if (!grst)
    begin
      rResult <= '0;
    end
    else if (xEn_i)
    begin
      rResult <= aluOut;
    end
  end

  assign result_o    = rResult;
  assign resultFwd_o = fwdA;          // Branch test operand
  assign dAddr_o     = fwdA + simm_i; // LWI / SWI effective address

endmodule

/* hw/regFile.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module regFile
  import corePkg::*;
(
  input  logic                gclk,
  input  logic                grst,
  input  logic                xEn_i,
  input  logic [4:0]          ra_i,
  input  logic [4:0]          rb_i,
  input  logic [4:0]          rd_i,
  input  logic [4:0]          rw_i,
  input  dstSelT              dstSel_i,
  input  logic [`CORE_DW-1:0] result_i,
  input  logic [`CORE_DW-1:0] dData_i,
  output logic [`CORE_DW-1:0] regA_o,
  output logic [`CORE_DW-1:0] regB_o,
  output logic [`CORE_DW-1:0] regD_o,
  output logic [`CORE_DW-1:0] loadData_o,
  output logic [`CORE_DW-1:0] dDataOut_o
);

  logic [`CORE_DW-1:0] regs [`CORE_NREG];
  logic [`CORE_DW-1:0] wData;
  logic                wrEn;

  // Write-back value, load data arrives this cycle
  assign wData = (dstSel_i == DST_LOAD) ? dData_i : result_i;
  assign wrEn  = (dstSel_i != DST_NONE) && (rw_i != 5'd0); // r0 never written

  always_ff @(posedge gclk)
  begin
    if (grst && xEn_i && wrEn)
    begin
      regs[rw_i] <= wData;
    end
  end

  // r0 reads as zero
  assign regA_o = (ra_i == 5'd0) ? '0 : regs[ra_i];
  assign regB_o = (rb_i == 5'd0) ? '0 : regs[rb_i];
  assign regD_o = (rd_i == 5'd0) ? '0 : regs[rd_i];

  // Last result for the execute forward path
  assign loadData_o = wData;

  // Store source, bypassed when rd is still in write-back
  assign dDataOut_o = (wrEn && (rd_i == rw_i)) ? wData : regD_o;

endmodule

/* hw/branchUnit.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module branchUnit
  import corePkg::*;
(
  input  logic                gclk,
  input  logic                grst,
  input  logic                xEn_i,
  input  opcT                 opc_i,
  input  logic [4:0]          rd_i,    // Branch condition code
  input  logic [`CORE_DW-1:0] regA_i,  // Forwarded ra
  input  logic [`CORE_DW-1:0] simm_i,
  output logic [`CORE_DW-1:0] iAddr_o,
  output logic [`CORE_DW-1:0] pc_o,
  output logic                skip_o
);

  logic [`CORE_DW-1:0] rPc;    // Address of the word now returning
  logic [`CORE_DW-1:0] xPc;    // PC of the instruction in execute
  logic                rSkip;
  logic                primed; // Clears after first advance
  logic                raZero;
  logic                taken;
  logic [`CORE_DW-1:0] target;

  assign raZero = (regA_i == '0);
  assign target = xPc + simm_i; // PC relative

  // rd 0 is BEQI, rd 1 is BNEI
  always_comb
  begin
    taken = 1'b0;
    if (opc_i == OPC_BRI)
      taken = 1'b1;
    else if (opc_i == OPC_BCCI)
      taken = ((rd_i == 5'd0) && raZero) || ((rd_i == 5'd1) && !raZero);
    if (rSkip)
      taken = 1'b0; // Squashed branch has no effect
  end

  // Pre-cycle fetch address
  assign iAddr_o = taken ? target : rPc + `CORE_DW'(4);

  always_ff @(posedge gclk)
  begin
    if (!grst)
    begin
      rPc    <= `CORE_RESET_PC - `CORE_DW'(4); // First fetch lands on reset PC
      xPc    <= '0;
      rSkip  <= 1'b1;
      primed <= 1'b0;
    end
    else if (xEn_i)
    begin
      rPc    <= iAddr_o;
      xPc    <= rPc;
      rSkip  <= taken || !primed; // First decoded word is not a fetch result
      primed <= 1'b1;
    end
  end

  assign pc_o   = xPc;
  assign skip_o = rSkip;

endmodule

/* hw/ctrlUnit.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module ctrlUnit
  import corePkg::*;
(
  input  logic       gclk,
  input  logic       grst,
  input  logic       xEn_i,
  input  logic       skip_i,
  input  opcT        opc_i,
  input  logic [4:0] rd_i,
  input  logic [4:0] ra_i,
  input  logic [4:0] rb_i,
  output srcSelT     srcSel_o,
  output tgtSelT     tgtSel_o,
  output aluSelT     aluSel_o,
  output dstSelT     dstSel_o,
  output logic [4:0] rw_o,
  output logic       dEn_o,
  output logic       dWe_o
);

  logic isWr;
  logic isLd;
  logic isSt;
  logic hitA;
  logic hitB;

  // Previous instruction still in write-back
  assign hitA = (ra_i == rw_o) && (rw_o != 5'd0);
  assign hitB = (rb_i == rw_o) && (rw_o != 5'd0);

  always_comb
  begin
    srcSel_o = hitA ? SRC_FWD : SRC_REGA;
    tgtSel_o = hitB ? TGT_FWD : TGT_REGB;
    aluSel_o = ALU_ADD;
    isWr     = 1'b0;
    isLd     = 1'b0;
    isSt     = 1'b0;
    case (opc_i)
      OPC_ADD:  isWr = 1'b1;
      OPC_RSUB:
      begin
        aluSel_o = ALU_RSUB;
        isWr     = 1'b1;
      end
      OPC_OR:
      begin
        aluSel_o = ALU_OR;
        isWr     = 1'b1;
      end
      OPC_AND:
      begin
        aluSel_o = ALU_AND;
        isWr     = 1'b1;
      end
      OPC_XOR:
      begin
        aluSel_o = ALU_XOR;
        isWr     = 1'b1;
      end
      OPC_ADDI:
      begin
        tgtSel_o = TGT_IMM;
        isWr     = 1'b1;
      end
      OPC_RSUBI:
      begin
        tgtSel_o = TGT_IMM;
        aluSel_o = ALU_RSUB;
        isWr     = 1'b1;
      end
      OPC_ORI:
      begin
        tgtSel_o = TGT_IMM;
        aluSel_o = ALU_OR;
        isWr     = 1'b1;
      end
      OPC_ANDI:
      begin
        tgtSel_o = TGT_IMM;
        aluSel_o = ALU_AND;
        isWr     = 1'b1;
      end
      OPC_XORI:
      begin
        tgtSel_o = TGT_IMM;
        aluSel_o = ALU_XOR;
        isWr     = 1'b1;
      end
      OPC_BSI:
      begin
        tgtSel_o = TGT_IMM;
        aluSel_o = ALU_SHIFT;
        isWr     = (`CORE_BSF != 0); // NOP without shifter
      end
      OPC_BRI:
      begin
        srcSel_o = SRC_PC; // ALU forms pc + imm, not written
        tgtSel_o = TGT_IMM;
      end
      OPC_BCCI: tgtSel_o = TGT_IMM; // ra stays forwarded for the test
      OPC_LWI:
      begin
        tgtSel_o = TGT_IMM;
        isLd     = 1'b1;
      end
      OPC_SWI:
      begin
        tgtSel_o = TGT_IMM;
        isSt     = 1'b1;
      end
      default: ; // Unsupported, no effect
    endcase
  end

  // One access per instruction, issued on the advancing cycle
  assign dEn_o = (isLd || isSt) && !skip_i && xEn_i;
  assign dWe_o = isSt && !skip_i && xEn_i;

  // Write-back stage register
  always_ff @(posedge gclk)
  begin
    if (!grst)
    begin
      rw_o     <= 5'd0;
      dstSel_o <= DST_NONE;
    end
    else if (xEn_i)
    begin
      rw_o     <= ((isWr || isLd) && !skip_i) ? rd_i : 5'd0;
      if (skip_i)
        dstSel_o <= DST_NONE; // Squashed slot
      else if (isLd)
        dstSel_o <= DST_LOAD;
      else if (isWr)
        dstSel_o <= DST_ALU;
      else
        dstSel_o <= DST_NONE;
    end
  end

endmodule

/* hw/instBuf.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module instBuf
  import corePkg::*;
(
  input  logic                gclk,
  input  logic                grst,
  input  logic                dEn_i,   // Decode advance
  input  logic [`CORE_DW-1:0] iData_i,
  output opcT                 opc_o,
  output logic [4:0]          rd_o,
  output logic [4:0]          ra_o,
  output logic [4:0]          rb_o,
  output logic [15:0]         imm_o,
  output logic [`CORE_DW-1:0] simm_o,
  output logic [10:0]         alt_o,
  output logic [`CORE_DW-1:0] iReg_o
);

  logic [`CORE_DW-1:0] iReg;

  // Instruction register, cleared word decodes as ADD r0
  always_ff @(posedge gclk)
  begin
    if (!grst)
    begin
      iReg <= '0;
    end
    else if (dEn_i)
    begin
      iReg <= iData_i; // Held under any stall
    end
  end

  // Field split
  assign opc_o  = opcT'(iReg[31:26]);
  assign rd_o   = iReg[25:21];
  assign ra_o   = iReg[20:16];
  assign rb_o   = iReg[15:11];
  assign imm_o  = iReg[15:0];
  assign alt_o  = iReg[10:0]; // Shift direction in bit 10

  // Sign extended immediate
  assign simm_o = {{(`CORE_DW-16){iReg[15]}}, iReg[15:0]};

  assign iReg_o = iReg;

endmodule

/* hw/corePkg.sv */
package corePkg;

  // Primary opcodes, MicroBlaze encoding
  typedef enum logic [5:0] {
    OPC_ADD   = 6'h00,
    OPC_RSUB  = 6'h01,
    OPC_ADDI  = 6'h08,
    OPC_RSUBI = 6'h09,
    OPC_BSI   = 6'h19, // BSLLI / BSRLI
    OPC_OR    = 6'h20,
    OPC_AND   = 6'h21,
    OPC_XOR   = 6'h22,
    OPC_ORI   = 6'h28,
    OPC_ANDI  = 6'h29,
    OPC_XORI  = 6'h2A,
    OPC_BRI   = 6'h2E,
    OPC_BCCI  = 6'h2F, // BEQI / BNEI, condition in rd
    OPC_LWI   = 6'h3A,
    OPC_SWI   = 6'h3E
  } opcT;

  // First operand source
  typedef enum logic [1:0] {
    SRC_REGA = 2'd0,
    SRC_FWD  = 2'd1,
    SRC_PC   = 2'd2
  } srcSelT;

  // Second operand source
  typedef enum logic [1:0] {
    TGT_REGB = 2'd0,
    TGT_FWD  = 2'd1,
    TGT_IMM  = 2'd2
  } tgtSelT;

  typedef enum logic [2:0] {
    ALU_ADD   = 3'd0,
    ALU_RSUB  = 3'd1, // b - a
    ALU_OR    = 3'd2,
    ALU_AND   = 3'd3,
    ALU_XOR   = 3'd4,
    ALU_SHIFT = 3'd5
  } aluSelT;

  // Write-back source
  typedef enum logic [1:0] {
    DST_NONE = 2'd0,
    DST_ALU  = 2'd1,
    DST_LOAD = 2'd2
  } dstSelT;

endpackage

/* hw/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Datapath and address width
`define CORE_DW 32

// Register file depth
`define CORE_NREG 32

// Barrel shifter build option, 0 leaves BSLLI/BSRLI out
`define CORE_BSF 1

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

`endif
